//--- list.f
source/cc_pkg.sv
source/spill_register.sv
source/cc_decode.sv
source/cc_execute.sv
source/cc_result.sv
source/cc_ipu.sv
source/cc_core_complex.sv
testbench/cc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core complex testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cc_tb -o cc_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/cc_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- source/cc_core_complex.sv
// --------------------------------------
// Core complex top level
// --------------------------------------
`timescale 1ns/1ns

module cc_core_complex import cc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  output logic [31:0] inst_addr_o,
  input  logic [31:0] inst_data_i,
  output logic        inst_valid_o,
  input  logic        inst_ready_i,
  output logic        retire_valid_o,
  output wb_t         retire_o
);

  decoded_t    dec;
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        alu_wb_valid;
  wb_t         alu_wb;
  logic        acc_done_valid;
  reg_idx_t    acc_done_idx;

  // Offload path, _d before and _q after each slice
  acc_req_t  acc_req_d;
  acc_req_t  acc_req_q;
  acc_resp_t acc_resp_d;
  acc_resp_t acc_resp_q;
  logic      acc_req_d_valid;
  logic      acc_req_d_ready;
  logic      acc_req_q_valid;
  logic      acc_req_q_ready;
  logic      acc_resp_d_valid;
  logic      acc_resp_d_ready;
  logic      acc_resp_q_valid;
  logic      acc_resp_q_ready;

  cc_decode i_decode (
    .inst_data_i ( inst_data_i ),
    .dec_o       ( dec         )
  );

  cc_execute i_execute (
    .clk_i,
    .rst_i,
    .inst_addr_o,
    .inst_valid_o,
    .inst_ready_i,
    .dec_i            ( dec             ),
    .rs1_idx_o        ( rs1_idx         ),
    .rs2_idx_o        ( rs2_idx         ),
    .rs1_data_i       ( rs1_data        ),
    .rs2_data_i       ( rs2_data        ),
    .alu_wb_valid_o   ( alu_wb_valid    ),
    .alu_wb_o         ( alu_wb          ),
    .acc_req_o        ( acc_req_d       ),
    .acc_req_valid_o  ( acc_req_d_valid ),
    .acc_req_ready_i  ( acc_req_d_ready ),
    .acc_done_valid_i ( acc_done_valid  ),
    .acc_done_idx_i   ( acc_done_idx    )
  );

  spill_register #(
    .T      ( acc_req_t      ),
    .Bypass ( !CutOffloadReq )
  ) i_spill_acc_req (
    .clk_i,
    .rst_i,
    .valid_i ( acc_req_d_valid ),
    .ready_o ( acc_req_d_ready ),
    .data_i  ( acc_req_d       ),
    .valid_o ( acc_req_q_valid ),
    .ready_i ( acc_req_q_ready ),
    .data_o  ( acc_req_q       )
  );

  cc_ipu i_ipu (
    .clk_i,
    .rst_i,
    .acc_req_i        ( acc_req_q        ),
    .acc_req_valid_i  ( acc_req_q_valid  ),
    .acc_req_ready_o  ( acc_req_q_ready  ),
    .acc_resp_o       ( acc_resp_d       ),
    .acc_resp_valid_o ( acc_resp_d_valid ),
    .acc_resp_ready_i ( acc_resp_d_ready )
  );

  spill_register #(
    .T      ( acc_resp_t      ),
    .Bypass ( !CutOffloadResp )
  ) i_spill_acc_resp (
    .clk_i,
    .rst_i,
    .valid_i ( acc_resp_d_valid ),
    .ready_o ( acc_resp_d_ready ),
    .data_i  ( acc_resp_d       ),
    .valid_o ( acc_resp_q_valid ),
    .ready_i ( acc_resp_q_ready ),
    .data_o  ( acc_resp_q       )
  );

  cc_result i_result (
    .clk_i,
    .rst_i,
    .rs1_idx_i        ( rs1_idx          ),
    .rs2_idx_i        ( rs2_idx          ),
    .rs1_data_o       ( rs1_data         ),
    .rs2_data_o       ( rs2_data         ),
    .alu_wb_valid_i   ( alu_wb_valid     ),
    .alu_wb_i         ( alu_wb           ),
    .acc_resp_i       ( acc_resp_q       ),
    .acc_resp_valid_i ( acc_resp_q_valid ),
    .acc_resp_ready_o ( acc_resp_q_ready ),
    .acc_done_valid_o ( acc_done_valid   ),
    .acc_done_idx_o   ( acc_done_idx     ),
    .retire_valid_o,
    .retire_o
  );

endmodule

//--- source/cc_decode.sv
// --------------------------------------
// Instruction decode for the RV32 subset
// --------------------------------------
`timescale 1ns/1ns

module cc_decode import cc_pkg::*; (
  input  logic [31:0] inst_data_i,
  output decoded_t    dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst_data_i[6:0];
  assign funct3 = inst_data_i[14:12];
  assign funct7 = inst_data_i[31:25];

  always_comb begin
    dec_o          = '0;
    dec_o.op_class = cls_illegal;
    dec_o.alu_op   = alu_add;
    dec_o.mul_op   = mul_mul;
    dec_o.rd       = inst_data_i[11:7];
    dec_o.rs1      = inst_data_i[19:15];
    case (opcode)
      opcode_op: begin
        dec_o.op_class = cls_alu;
        dec_o.rs2      = inst_data_i[24:20];
        case ({funct7, funct3})
          10'b0000000_000: dec_o.alu_op = alu_add;
          10'b0100000_000: dec_o.alu_op = alu_sub;
          10'b0000000_100: dec_o.alu_op = alu_xor;
          10'b0000000_110: dec_o.alu_op = alu_or;
          10'b0000000_111: dec_o.alu_op = alu_and;
          10'b0000001_000: dec_o.op_class = cls_offload;
          10'b0000001_001: begin
            dec_o.op_class = cls_offload;
            dec_o.mul_op   = mul_mulh;
          end
          10'b0000001_011: begin
            dec_o.op_class = cls_offload;
            dec_o.mul_op   = mul_mulhu;
          end
          default: dec_o.op_class = cls_illegal;
        endcase
      end
      opcode_op_imm: begin
        // ADDI only; rs2 stays x0 so the immediate bits raise no hazard
        if (funct3 == 3'b000) begin
          dec_o.op_class = cls_alu;
          dec_o.use_imm  = 1'b1;
          dec_o.imm      = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
        end
      end
      opcode_lui: begin
        dec_o.op_class = cls_alu;
        dec_o.alu_op   = alu_lui;
        dec_o.rs1      = '0;
        dec_o.use_imm  = 1'b1;
        dec_o.imm      = {inst_data_i[31:12], 12'h000};
      end
      default: dec_o.op_class = cls_illegal;
    endcase

    // Illegal words act as a no-op with no register operands
    if (dec_o.op_class == cls_illegal) begin
      dec_o.rd  = '0;
      dec_o.rs1 = '0;
      dec_o.rs2 = '0;
    end
    dec_o.writes_rd = (dec_o.op_class != cls_illegal) && (dec_o.rd != '0);
  end

endmodule

//--- source/cc_execute.sv
// --------------------------------------
// Fetch, scoreboard, ALU and offload issue
// --------------------------------------
`timescale 1ns/1ns

module cc_execute import cc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Instruction port
  output logic [31:0] inst_addr_o,
  output logic        inst_valid_o,
  input  logic        inst_ready_i,
  input  decoded_t    dec_i,
  // Register file reads
  output reg_idx_t    rs1_idx_o,
  output reg_idx_t    rs2_idx_o,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  // ALU writeback
  output logic        alu_wb_valid_o,
  output wb_t         alu_wb_o,
  // Offload request and completion
  output acc_req_t    acc_req_o,
  output logic        acc_req_valid_o,
  input  logic        acc_req_ready_i,
  input  logic        acc_done_valid_i,
  input  reg_idx_t    acc_done_idx_i
);

  logic [31:0] pc_q;
  logic        fetch_en_q;
  logic [31:0] sb_q;
  logic [31:0] sb_d;
  logic        fetched;
  logic        hazard;
  logic        is_offload;
  logic        issue;
  logic [31:0] opb;
  logic [31:0] alu_result;

  assign inst_addr_o  = pc_q;
  assign inst_valid_o = fetch_en_q;
  assign fetched      = inst_valid_o && inst_ready_i;

  // Any register touched by a pending offload blocks issue (RAW and WAW)
  assign hazard     = sb_q[dec_i.rs1] || sb_q[dec_i.rs2] || sb_q[dec_i.rd];
  assign is_offload = dec_i.op_class == cls_offload;
  assign issue      = fetched && !hazard && (!is_offload || acc_req_ready_i);

  assign rs1_idx_o = dec_i.rs1;
  assign rs2_idx_o = dec_i.rs2;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  assign opb = dec_i.use_imm ? dec_i.imm : rs2_data_i;

  always_comb begin
    case (dec_i.alu_op)
      alu_sub: alu_result = rs1_data_i - opb;
      alu_xor: alu_result = rs1_data_i ^ opb;
      alu_or:  alu_result = rs1_data_i | opb;
      alu_and: alu_result = rs1_data_i & opb;
      alu_lui: alu_result = dec_i.imm;
      default: alu_result = rs1_data_i + opb;
    endcase
  end

  assign alu_wb_valid_o = issue && (dec_i.op_class == cls_alu) && dec_i.writes_rd;
  assign alu_wb_o.rd    = dec_i.rd;
  assign alu_wb_o.data  = alu_result;

  // ----------------------------------------
  // Offload issue
  // ----------------------------------------
  assign acc_req_valid_o  = fetched && is_offload && !hazard;
  assign acc_req_o.id     = dec_i.rd;
  assign acc_req_o.mul_op = dec_i.mul_op;
  assign acc_req_o.arga   = rs1_data_i;
  assign acc_req_o.argb   = rs2_data_i;

  always_comb begin
    sb_d = sb_q;
    if (acc_done_valid_i) begin
      sb_d[acc_done_idx_i] = 1'b0;
    end
    if (issue && is_offload && dec_i.writes_rd) begin
      sb_d[dec_i.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc_q       <= BootAddr;
      fetch_en_q <= 1'b0;
      sb_q       <= '0;
    end else begin
      fetch_en_q <= 1'b1;
      sb_q       <= sb_d;
      if (issue) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // A destination completing this cycle is still owed by the IPU
  assert property (@(posedge clk_i) disable iff (rst_i)
    issue && dec_i.writes_rd && acc_done_valid_i |-> acc_done_idx_i != dec_i.rd);

  // Held PC and untouched operands keep a stalled request steady
  assert property (@(posedge clk_i) disable iff (rst_i)
    acc_req_valid_o && !acc_req_ready_i |=> !acc_req_valid_o || $stable(acc_req_o));

endmodule

//--- source/cc_ipu.sv
// --------------------------------------
// Two-stage pipelined integer multiplier
// --------------------------------------
`timescale 1ns/1ns

module cc_ipu import cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  logic               advance;
  logic               s1_valid_q;
  logic               pvalid_q;
  reg_idx_t           s1_id_q;
  mul_op_e            s1_op_q;
  logic [63:0]        s1_prod_q;
  logic signed [32:0] opa;
  logic signed [32:0] opb;
  logic signed [63:0] prod;
  acc_resp_t          resp_q;

  // Pipeline freezes as a whole while the output is held
  assign advance         = !pvalid_q || acc_resp_ready_i;
  assign acc_req_ready_o = advance;

  // Only MULH treats operands as signed; the low word is the same for all
  assign opa  = {(acc_req_i.mul_op == mul_mulh) && acc_req_i.arga[31], acc_req_i.arga};
  assign opb  = {(acc_req_i.mul_op == mul_mulh) && acc_req_i.argb[31], acc_req_i.argb};
  assign prod = 64'(opa) * 64'(opb);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      pvalid_q   <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= acc_req_valid_i;
      pvalid_q   <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_id_q     <= acc_req_i.id;
      s1_op_q     <= acc_req_i.mul_op;
      s1_prod_q   <= prod;
      resp_q.id   <= s1_id_q;
      resp_q.data <= (s1_op_q == mul_mul) ? s1_prod_q[31:0] : s1_prod_q[63:32];
    end
  end

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = pvalid_q;

endmodule

//--- source/cc_pkg.sv
// --------------------------------------
// Core complex constants, operation enums
// and the records passed between blocks
// --------------------------------------
package cc_pkg;

  // Reset PC
  localparam logic [31:0] BootAddr = 32'h0000_1000;

  // Register slices on the offload path
  localparam bit CutOffloadReq  = 1'b1;
  localparam bit CutOffloadResp = 1'b1;

  // RV32 major opcodes in the supported subset
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [1:0] {
    cls_alu,
    cls_offload,
    cls_illegal
  } op_class_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    mul_mul,
    mul_mulh,
    mul_mulhu
  } mul_op_e;

  typedef struct packed {
    op_class_e   op_class;
    alu_op_e     alu_op;
    mul_op_e     mul_op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] imm;
    logic        use_imm;
    logic        writes_rd;
  } decoded_t;

  // Offload request, id names the destination register
  typedef struct packed {
    reg_idx_t    id;
    mul_op_e     mul_op;
    logic [31:0] arga;
    logic [31:0] argb;
  } acc_req_t;

  typedef struct packed {
    reg_idx_t    id;
    logic [31:0] data;
  } acc_resp_t;

  typedef struct packed {
    reg_idx_t    rd;
    logic [31:0] data;
  } wb_t;

endpackage

//--- source/cc_result.sv
// --------------------------------------
// Register file, writeback merge, retire
// --------------------------------------
`timescale 1ns/1ns

module cc_result import cc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  reg_idx_t    rs1_idx_i,
  input  reg_idx_t    rs2_idx_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o,
  input  logic        alu_wb_valid_i,
  input  wb_t         alu_wb_i,
  input  acc_resp_t   acc_resp_i,
  input  logic        acc_resp_valid_i,
  output logic        acc_resp_ready_o,
  output logic        acc_done_valid_o,
  output reg_idx_t    acc_done_idx_o,
  output logic        retire_valid_o,
  output wb_t         retire_o
);

  logic [31:0] regs_q [1:31];
  logic        acc_fire;
  logic        wr_en;
  wb_t         wr;
  logic        retire_valid_q;
  wb_t         retire_q;

  // x0 is hardwired
  assign rs1_data_o = (rs1_idx_i == '0) ? 32'h0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? 32'h0 : regs_q[rs2_idx_i];

  // ALU owns the write port, responses take the idle cycles
  assign acc_resp_ready_o = !alu_wb_valid_i;
  assign acc_fire         = acc_resp_valid_i && acc_resp_ready_o;
  assign acc_done_valid_o = acc_fire;
  assign acc_done_idx_o   = acc_resp_i.id;

  assign wr    = alu_wb_valid_i ? alu_wb_i : wb_t'{rd: acc_resp_i.id, data: acc_resp_i.data};
  assign wr_en = (alu_wb_valid_i || acc_fire) && (wr.rd != '0);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs_q[wr.rd] <= wr.data;
      retire_q      <= wr;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= wr_en;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;

  // The issue stage keeps both sources off the same register
  assert property (@(posedge clk_i) disable iff (rst_i)
    alu_wb_valid_i && acc_resp_valid_i |-> alu_wb_i.rd != acc_resp_i.id);

endmodule

//--- source/spill_register.sv
// --------------------------------------
// Two-entry valid/ready register slice
// --------------------------------------
`timescale 1ns/1ns

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic a_full_q;
    logic b_full_q;
    T     a_data_q;
    T     b_data_q;
    logic a_fill;
    logic a_drain;
    logic b_fill;
    logic b_drain;

    // Entry a takes new data, entry b holds the older item on a stall
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Both directions come straight from flops
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // An offered item stays put until the consumer takes it
    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

//--- testbench/cc_tb.sv
// --------------------------------------
// Core complex testbench with program and
// expected retires from a data file
// --------------------------------------
`timescale 1ns/1ns

module cc_tb import cc_pkg::*; ();

  localparam int          ConsumeTimeout = 4000;
  localparam int          DrainTimeout   = 400;
  localparam int          SettleCycles   = 20;
  localparam logic [31:0] NopWord        = 32'h0000_0013;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] inst_addr;
  logic [31:0] inst_data;
  logic        inst_valid;
  logic        inst_ready;
  logic        retire_valid;
  wb_t         retire;

  // Program words and expected values per destination register
  logic [31:0] prog_q [$];
  logic [31:0] exp_q [32][$];
  logic [31:0] lfsr_state;

  cc_core_complex dut (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .inst_addr_o    ( inst_addr    ),
    .inst_data_i    ( inst_data    ),
    .inst_valid_o   ( inst_valid   ),
    .inst_ready_i   ( inst_ready   ),
    .retire_valid_o ( retire_valid ),
    .retire_o       ( retire       )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------
  // Helpers
  // --------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    // Taps 32, 22, 2, 1
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  function automatic logic take_random_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_error($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                name, got, expected));
    end
  endtask

  task automatic load_tests();
    int               fd;
    int               fields;
    logic [8*128-1:0] line;
    logic [31:0]      word;
    logic [31:0]      rd;
    logic [31:0]      value;
    fd = $fopen("testbench/cc_tests.txt", "r");
    if (fd == 0) begin
      stop_with_error("Could not open testbench/cc_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) > 0) begin
          // Comment lines parse to fewer than three fields
          fields = $sscanf(line, "%h %h %h", word, rd, value);
          if (fields == 3) begin
            if (rd == 32'd0 || rd > 32'd31) begin
              stop_with_error("Test file names a register that cannot be written");
            end else begin
              prog_q.push_back(word);
              exp_q[rd[4:0]].push_back(value);
            end
          end
        end
      end
      $fclose(fd);
      if (prog_q.size() == 0) begin
        stop_with_error("Test file holds no instructions");
      end
    end
  endtask

  function automatic int pending_results();
    int total;
    total = 0;
    for (int r = 0; r < 32; r++) begin
      total += exp_q[r].size();
    end
    return total;
  endfunction

  task automatic check_retire();
    logic [31:0] expected;
    if (retire.rd == '0) begin
      stop_with_error("A result was retired to register x0");
    end else if (exp_q[retire.rd].size() == 0) begin
      stop_with_error($sformatf("Unexpected retire to register x%0d", retire.rd));
    end else begin
      expected = exp_q[retire.rd].pop_front();
      check_equal($sformatf("retire_o.data (x%0d)", retire.rd), retire.data, expected);
    end
  endtask

  // Check the retire port and answer the fetch for one cycle
  task automatic service_cycle();
    logic [31:0] word_idx;
    logic        bit_a;
    logic        bit_b;
    @(negedge clk_i);
    check_equal("inst_valid_o", 32'(inst_valid), 32'd1);
    if (retire_valid) begin
      check_retire();
    end
    word_idx = (inst_addr - BootAddr) >> 2;
    if (word_idx < prog_q.size()) begin
      inst_data = prog_q[word_idx];
    end else begin
      inst_data = NopWord;
    end
    // Ready three cycles out of four on average
    bit_a = take_random_bit();
    bit_b = take_random_bit();
    inst_ready = bit_a | bit_b;
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial begin
    int          cycles;
    logic [31:0] end_addr;
    rst_i      = 1'b1;
    inst_data  = NopWord;
    inst_ready = 1'b0;
    lfsr_state = 32'h9a0;
    load_tests();
    end_addr = BootAddr + 32'(prog_q.size() * 4);

    repeat (3) @(negedge clk_i);
    check_equal("inst_valid_o", 32'(inst_valid), 32'd0);
    check_equal("retire_valid_o", 32'(retire_valid), 32'd0);
    rst_i = 1'b0;

    // Run until the PC has moved past the last word
    cycles = 0;
    while (inst_addr < end_addr) begin
      if (cycles == ConsumeTimeout) begin
        stop_with_error("Timeout: the program was not consumed");
      end else begin
        service_cycle();
        cycles++;
      end
    end

    // Offloads still in flight
    cycles = 0;
    while (pending_results() != 0) begin
      if (cycles == DrainTimeout) begin
        stop_with_error($sformatf("Timeout: %0d expected results never retired",
                                  pending_results()));
      end else begin
        service_cycle();
        cycles++;
      end
    end

    // Late or duplicate retires show up here
    repeat (SettleCycles) service_cycle();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- testbench/cc_tests.txt
# columns: instruction word, destination register, expected value (all hex)
# registers start at zero, one instruction per line in program order
ffb00093 01 fffffffb
00700113 02 00000007
002081b3 03 00000002
40110233 04 0000000c
0020c2b3 05 fffffffc
0020e333 06 ffffffff
0020f3b3 07 00000003
12345437 08 12345000
022084b3 09 ffffffdd
02209533 0a ffffffff
0220b5b3 0b 00000006
00248633 0c ffffffe4
022406b3 0d 7f6e3000
022106b3 0d 00000031
02841733 0e 014b65f0
0210b7b3 0f fffffff6
02109833 10 00000000
00f6c8b3 11 ffffffc7
